// ==== Makefile ====
# Verilator build and run for the TCDM testbench

TOP := tcdm_tb

.PHONY: all build run lint clean

all: run

build:
	verilator --binary --timing --assert --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP) -o V$(TOP)

# pass only when the testbench prints its pass line
run: build
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -qx 'ALL CHECKS PASSED'

lint:
	verilator --lint-only --timing --timescale 1ns/1ps \
		-f vlog.f --top-module $(TOP)

clean:
	rm -rf obj_dir

// ==== dv/tcdm_patterns.txt ====
# columns: port op byte_addr data strobe expect, port a or b (ab for both ports)
# op w r p f c, data r = random, expect - none, mdl model, err pslverr, else read data
a f 000 40 f -
a w 100 12345678 f -
a r 100 0 f 12345678
a w 104 ffffffff f -
a w 104 000000aa 1 -
a r 104 0 f ffffffaa
a w 108 11223344 f -
a w 108 aabbccdd 6 -
a r 108 0 f 11bbcc44
a w 10c 00000000 f -
a w 10c 55667788 9 -
a r 10c 0 f 55000088
b w 110 r f -
b w 110 0 c -
a r 110 0 f mdl
a r 0fc 0 f mdl
ab p 0f0 r f mdl
b r 0f0 0 f mdl
ab p 020 9abcdef0 3 mdl
b r 020 0 f mdl
ab c 000 20 f mdl
a w 400 deadbeef f err
a r 000 0 f mdl
b r ffc 0 f err
b w 404 r f err
b r 004 0 f mdl

// ==== dv/tcdm_tb.sv ====
`default_nettype none

module tcdm_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int MAX_WAIT = 20;

  logic clk_i;
  logic rst_ni;

  // index 0 is port A, index 1 is port B
  logic [1:0]                                  psel;
  logic [1:0]                                  penable;
  logic [1:0]                                  pwrite;
  logic [1:0][11:0]                            paddr;
  logic [1:0][tcdm_pkg::TCDM_DATA_W-1:0]       pwdata;
  logic [1:0][tcdm_pkg::TCDM_STRB_W-1:0]       pstrb;
  wire  [1:0][tcdm_pkg::TCDM_DATA_W-1:0]       prdata;
  wire  [1:0]                                  pready;
  wire  [1:0]                                  pslverr;

  // reference copy of the memory contents
  logic [31:0] shadow [1024];
  integer      seed = 74913;
  int          errors = 0;
  int          tests_run = 0;
  int          tests_failed = 0;

  tcdm_top #(
    .BANK_DEPTH (64)
  ) UUT (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .a_psel_i    (psel[0]),
    .a_penable_i (penable[0]),
    .a_pwrite_i  (pwrite[0]),
    .a_paddr_i   (paddr[0]),
    .a_pwdata_i  (pwdata[0]),
    .a_pstrb_i   (pstrb[0]),
    .a_prdata_o  (prdata[0]),
    .a_pready_o  (pready[0]),
    .a_pslverr_o (pslverr[0]),
    .b_psel_i    (psel[1]),
    .b_penable_i (penable[1]),
    .b_pwrite_i  (pwrite[1]),
    .b_paddr_i   (paddr[1]),
    .b_pwdata_i  (pwdata[1]),
    .b_pstrb_i   (pstrb[1]),
    .b_prdata_o  (prdata[1]),
    .b_pready_o  (pready[1]),
    .b_pslverr_o (pslverr[1])
  );

  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  task automatic check_low(input string name, input logic value);
    if (value !== 1'b0) begin
      $display("CHECK FAILED at %t: %s expected 0, got %b", $time, name, value);
      errors++;
    end
  endtask

  task automatic check_quiet();
    check_low("a_pready_o", pready[0]);
    check_low("b_pready_o", pready[1]);
    check_low("a_pslverr_o", pslverr[0]);
    check_low("b_pslverr_o", pslverr[1]);
  endtask

  // one APB transfer, entered and left 5 ns after a rising edge
  task automatic apb_xfer(input logic port, input logic wr, input logic [11:0] addr,
                          input logic [31:0] data, input logic [3:0] strb,
                          output logic [31:0] rdata, output logic err, output int cycles);
    logic done;
    done   = 1'b0;
    cycles = 0;
    rdata  = '0;
    err    = 1'b0;
    psel[port]    = 1'b1;
    penable[port] = 1'b0;
    pwrite[port]  = wr;
    paddr[port]   = addr;
    pwdata[port]  = data;
    pstrb[port]   = strb;
    @(posedge clk_i);
    #5;
    penable[port] = 1'b1;
    // outputs change just after the rising edge, so sample on the falling one
    while (!done && cycles < MAX_WAIT) begin
      @(negedge clk_i);
      cycles++;
      if (pready[port]) begin
        done  = 1'b1;
        rdata = prdata[port];
        err   = pslverr[port];
      end
    end
    if (!done) begin
      $display("timeout at %t: port %s gave no pready within %0d cycles",
               $time, port ? "B" : "A", MAX_WAIT);
      errors++;
    end
    @(posedge clk_i);
    #5;
    psel[port]    = 1'b0;
    penable[port] = 1'b0;
  endtask

  task automatic check_xfer(input logic port, input logic wr, input logic [11:0] addr,
                            input logic [31:0] data, input logic [3:0] strb,
                            input logic [31:0] rdata, input logic err, input int cycles,
                            input int max_cycles, input logic exp_err,
                            input logic use_lit, input logic [31:0] lit);
    string       pfx;
    logic [9:0]  idx;
    logic [31:0] exp_data;
    pfx = port ? "b" : "a";
    idx = addr[11:2];
    if (cycles < 2 || cycles > max_cycles) begin
      $display("port %s access phase at 0x%h took %0d cycles, allowed 2 to %0d",
               pfx, addr, cycles, max_cycles);
      errors++;
    end
    if (err !== exp_err) begin
      $display("CHECK FAILED at %t: %s_pslverr_o expected %b, got %b",
               $time, pfx, exp_err, err);
      errors++;
    end
    if (!exp_err) begin
      if (wr) begin
        // only enabled byte lanes take the new data
        for (int i = 0; i < 4; i++) begin
          if (strb[i]) begin
            shadow[idx][i*8 +: 8] = data[i*8 +: 8];
          end
        end
      end else begin
        exp_data = use_lit ? lit : shadow[idx];
        if (rdata !== exp_data) begin
          $display("CHECK FAILED at %t: %s_prdata_o at 0x%h expected %h, got %h",
                   $time, pfx, addr, exp_data, rdata);
          errors++;
        end
      end
    end
  endtask

  // fill pattern carries the whole word index in both halves
  task automatic fill_words(input logic [9:0] base, input int count);
    logic [9:0]  idx;
    logic [31:0] rd;
    logic        err;
    int          cyc;
    for (int i = 0; i < count; i++) begin
      idx = base + 10'(i);
      apb_xfer(1'b0, 1'b1, {idx, 2'b00}, {6'h2b, idx, 6'h15, idx}, 4'hf, rd, err, cyc);
      check_xfer(1'b0, 1'b1, {idx, 2'b00}, {6'h2b, idx, 6'h15, idx}, 4'hf,
                 rd, err, cyc, 2, 1'b0, 1'b0, '0);
    end
  endtask

  // back-to-back reads, port B walks the range downwards
  task automatic read_run(input logic port, input logic [9:0] base, input int count);
    logic [9:0]  idx;
    logic [31:0] rd;
    logic        err;
    int          cyc;
    for (int i = 0; i < count; i++) begin
      idx = port ? base + 10'(count - 1 - i) : base + 10'(i);
      apb_xfer(port, 1'b0, {idx, 2'b00}, '0, 4'hf, rd, err, cyc);
      check_xfer(port, 1'b0, {idx, 2'b00}, '0, 4'hf, rd, err, cyc, 3, 1'b0, 1'b0, '0);
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests_run++;
    if (errors == err_before) begin
      $display("test %0d %s: ok", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: FAILED with %0d errors", tests_run, name, errors - err_before);
    end
  endtask

  initial begin
    int          fd;
    int          n;
    int          line_no;
    int          err_before;
    string       line;
    string       port_s;
    string       op_s;
    string       data_s;
    string       exp_s;
    logic [11:0] addr;
    logic [31:0] data;
    logic [31:0] lit;
    logic [3:0]  strb;
    logic        port;
    logic        exp_err;
    logic        use_lit;
    logic [31:0] rd_a;
    logic [31:0] rd_b;
    logic        err_a;
    logic        err_b;
    int          cyc_a;
    int          cyc_b;

    $timeformat(-9, 0, " ns", 0);
    psel    = '0;
    penable = '0;
    pwrite  = '0;
    paddr   = '0;
    pwdata  = '0;
    pstrb   = '0;
    rst_ni  = 1'b0;

    err_before = errors;
    for (int i = 0; i < 10; i++) begin
      @(negedge clk_i);
      check_quiet();
    end
    @(posedge clk_i);
    #5;
    rst_ni = 1'b1;
    @(negedge clk_i);
    check_quiet();
    report_test("reset state", err_before);

    fd = $fopen("dv/tcdm_patterns.txt", "r");
    if (fd == 0) begin
      $display("could not open dv/tcdm_patterns.txt, no pattern tests were run");
      errors++;
    end else begin
      @(posedge clk_i);
      #5;
      line_no = 0;
      while (!$feof(fd)) begin
        line = "";
        n = $fgets(line, fd);
        line_no++;
        if (n == 0 || line.substr(0, 0) == "#") begin
          continue;
        end
        n = $sscanf(line, "%s %s %h %s %h %s", port_s, op_s, addr, data_s, strb, exp_s);
        if (n <= 0) begin
          continue;
        end
        if (n != 6) begin
          $display("pattern line %0d is malformed and was skipped", line_no);
          errors++;
          continue;
        end
        if (data_s == "r") begin
          data = $random(seed);
        end else begin
          n = $sscanf(data_s, "%h", data);
        end
        exp_err = (exp_s == "err");
        use_lit = !(exp_s == "err" || exp_s == "-" || exp_s == "mdl");
        lit     = '0;
        if (use_lit) begin
          n = $sscanf(exp_s, "%h", lit);
        end
        port       = (port_s == "b");
        err_before = errors;
        case (op_s)
          "w", "r": begin
            apb_xfer(port, op_s == "w", addr, data, strb, rd_a, err_a, cyc_a);
            check_xfer(port, op_s == "w", addr, data, strb, rd_a, err_a, cyc_a, 2,
                       exp_err, use_lit, lit);
          end
          "p": begin
            // A writes while B reads four words higher, same bank
            fork
              apb_xfer(1'b0, 1'b1, addr, data, strb, rd_a, err_a, cyc_a);
              apb_xfer(1'b1, 1'b0, addr + 12'h010, '0, 4'hf, rd_b, err_b, cyc_b);
            join
            check_xfer(1'b0, 1'b1, addr, data, strb, rd_a, err_a, cyc_a, 3,
                       1'b0, 1'b0, '0);
            check_xfer(1'b1, 1'b0, addr + 12'h010, '0, 4'hf, rd_b, err_b, cyc_b, 3,
                       exp_err, use_lit, lit);
          end
          "f": begin
            fill_words(addr[11:2], int'(data));
          end
          "c": begin
            fork
              read_run(1'b0, addr[11:2], int'(data));
              read_run(1'b1, addr[11:2], int'(data));
            join
          end
          default: begin
            $display("pattern line %0d has unknown operation %s", line_no, op_s);
            errors++;
          end
        endcase
        report_test($sformatf("line %0d %s %s 0x%h", line_no, port_s, op_s, addr),
                    err_before);
      end
      $fclose(fd);
    end

    $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== src/apb_mem_port.sv ====
`default_nettype none

module apb_mem_port #(
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // APB slave
  input  logic                             psel_i,
  input  logic                             penable_i,
  input  logic                             pwrite_i,
  input  logic [11:0]                      paddr_i,
  input  logic [tcdm_pkg::TCDM_DATA_W-1:0] pwdata_i,
  input  logic [tcdm_pkg::TCDM_STRB_W-1:0] pstrb_i,
  output logic [tcdm_pkg::TCDM_DATA_W-1:0] prdata_o,
  output logic                             pready_o,
  output logic                             pslverr_o,

  mem_req_if.requester                     mem
);

  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_DONE = 2'd2;

  logic [1:0]                state_q;
  logic [1:0]                state_d;
  logic                      err_q;
  logic                      err_d;
  logic                      access;
  logic                      in_range;
  tcdm_pkg::tcdm_word_addr_u word_addr;

  assign word_addr.index = paddr_i[tcdm_pkg::TCDM_ADDR_W+1:2];

  // rows past the configured depth never reach the memory
  assign in_range = 32'(word_addr.fields.row) < BANK_DEPTH;

  // access phase of an APB transfer
  assign access = psel_i && penable_i;

  // request fields come straight from APB, which holds them stable
  assign mem.we    = pwrite_i;
  assign mem.addr  = word_addr;
  assign mem.wdata = pwdata_i;
  assign mem.be    = pstrb_i;

  always_comb begin
    state_d = state_q;
    err_d   = err_q;
    mem.req = 1'b0;
    case (state_q)
      ST_IDLE: begin
        if (access) begin
          if (in_range) begin
            mem.req = 1'b1;
            err_d   = 1'b0;
            state_d = mem.gnt ? ST_DONE : ST_WAIT;
          end else begin
            // out of range, complete right away with an error
            err_d   = 1'b1;
            state_d = ST_DONE;
          end
        end
      end
      ST_WAIT: begin
        // keep asking until the arbiter lets us through
        mem.req = 1'b1;
        if (mem.gnt) begin
          state_d = ST_DONE;
        end
      end
      default: begin
        // ST_DONE lasts one cycle, back to idle for the next setup phase
        state_d = ST_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= ST_IDLE;
      err_q   <= 1'b0;
    end else begin
      state_q <= state_d;
      err_q   <= err_d;
    end
  end

  assign pready_o  = (state_q == ST_DONE);
  assign pslverr_o = pready_o && err_q;

  // read data arrives together with the completion cycle
  assign prdata_o = mem.rvalid ? mem.rdata : '0;

  // the master must still be in its access phase when we complete
  a_pready_in_access: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    pready_o |-> (psel_i && penable_i)
  ) else $error("pready raised outside an APB access phase");

endmodule

`default_nettype wire

// ==== src/mem_arbiter.sv ====
`default_nettype none

module mem_arbiter (
  input  logic         clk_i,
  input  logic         rst_ni,

  mem_req_if.responder req0,
  mem_req_if.responder req1,
  mem_req_if.requester mem
);

  // high when input 1 won the last grant
  logic last_q;
  // input that owns the read now in flight
  logic owner_q;
  logic pick1;

  // input 1 wins when alone, or on a tie if input 0 went last
  assign pick1 = req1.req && (!req0.req || !last_q);

  // forward the chosen request
  assign mem.req   = req0.req || req1.req;
  assign mem.we    = pick1 ? req1.we    : req0.we;
  assign mem.addr  = pick1 ? req1.addr  : req0.addr;
  assign mem.wdata = pick1 ? req1.wdata : req0.wdata;
  assign mem.be    = pick1 ? req1.be    : req0.be;

  assign req0.gnt = mem.gnt && req0.req && !pick1;
  assign req1.gnt = mem.gnt && pick1;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      // input 0 gets the first tie
      last_q  <= 1'b1;
      owner_q <= 1'b0;
    end else if (mem.req && mem.gnt) begin
      last_q <= pick1;
      if (!mem.we) begin
        owner_q <= pick1;
      end
    end
  end

  // response goes back only to the input that issued the read
  assign req0.rvalid = mem.rvalid && !owner_q;
  assign req1.rvalid = mem.rvalid && owner_q;
  assign req0.rdata  = owner_q ? '0 : mem.rdata;
  assign req1.rdata  = owner_q ? mem.rdata : '0;

  // an input that lost to the other one is served in the next cycle
  a_req0_served_next: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req0.req && req1.gnt) |=> req0.gnt
  ) else $error("input 0 not granted in the cycle after losing");

  a_req1_served_next: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (req1.req && req0.gnt) |=> req1.gnt
  ) else $error("input 1 not granted in the cycle after losing");

  // a response on an input needs a granted read from that input one cycle back
  a_rvalid0_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req0.rvalid |-> $past(req0.gnt && !req0.we)
  ) else $error("rvalid on input 0 without a granted read");

  a_rvalid1_after_read: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    req1.rvalid |-> $past(req1.gnt && !req1.we)
  ) else $error("rvalid on input 1 without a granted read");

endmodule

`default_nettype wire

// ==== src/mem_req_if.sv ====
`default_nettype none

interface mem_req_if;

  // request, held until gnt
  logic                              req;
  logic                              gnt;
  logic                              we;
  tcdm_pkg::tcdm_word_addr_u         addr;
  logic [tcdm_pkg::TCDM_DATA_W-1:0]  wdata;
  logic [tcdm_pkg::TCDM_STRB_W-1:0]  be;

  // read response, one cycle after the grant
  logic                              rvalid;
  logic [tcdm_pkg::TCDM_DATA_W-1:0]  rdata;

  modport requester (
    output req, we, addr, wdata, be,
    input  gnt, rvalid, rdata
  );

  modport responder (
    input  req, we, addr, wdata, be,
    output gnt, rvalid, rdata
  );

endinterface

`default_nettype wire

// ==== src/sram.sv ====
`default_nettype none

module sram #(
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic         clk_i,
  input  logic         rst_ni,

  mem_req_if.responder mem
);

  localparam int unsigned ROW_IDX_W = (BANK_DEPTH > 1) ? $clog2(BANK_DEPTH) : 1;

  logic [ROW_IDX_W-1:0]                 row_idx;
  logic [tcdm_pkg::TCDM_BANK_SEL_W-1:0] bank_sel_q;
  logic                                 rvalid_q;
  logic [tcdm_pkg::TCDM_DATA_W-1:0]     cut_rdata [tcdm_pkg::TCDM_BANKS];

  // single port, one access per cycle, never stalls
  assign mem.gnt = 1'b1;

  assign row_idx = mem.addr.fields.row[ROW_IDX_W-1:0];

  for (genvar b = 0; b < tcdm_pkg::TCDM_BANKS; b++) begin : gen_cut
    logic [tcdm_pkg::TCDM_DATA_W-1:0] cells [BANK_DEPTH];
    logic [tcdm_pkg::TCDM_DATA_W-1:0] q;
    logic                             cut_en;

    // low word-address bits pick the cut
    assign cut_en = mem.req && (int'(mem.addr.fields.bank) == b);

    always_ff @(posedge clk_i) begin
      if (cut_en) begin
        if (mem.we) begin
          // byte lanes with a clear enable keep their old value
          for (int unsigned i = 0; i < tcdm_pkg::TCDM_STRB_W; i++) begin
            if (mem.be[i]) begin
              cells[row_idx][i*8 +: 8] <= mem.wdata[i*8 +: 8];
            end
          end
        end else begin
          q <= cells[row_idx];
        end
      end
    end

    assign cut_rdata[b] = q;
  end

  // remember which cut answers, the way the output mux of a cut array works
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      bank_sel_q <= '0;
      rvalid_q   <= 1'b0;
    end else begin
      rvalid_q <= mem.req && !mem.we;
      if (mem.req && !mem.we) begin
        bank_sel_q <= mem.addr.fields.bank;
      end
    end
  end

  assign mem.rdata  = cut_rdata[bank_sel_q];
  assign mem.rvalid = rvalid_q;

  // the ports filter rows beyond the depth, nothing else should get here
  a_row_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    mem.req |-> (32'(mem.addr.fields.row) < BANK_DEPTH)
  ) else $error("memory request with row beyond BANK_DEPTH");

endmodule

`default_nettype wire

// ==== src/tcdm_pkg.sv ====
`default_nettype none

package tcdm_pkg;

  // data path
  localparam int unsigned TCDM_DATA_W = 32;
  localparam int unsigned TCDM_STRB_W = TCDM_DATA_W / 8;

  // memory organization, words interleaved over the banks
  localparam int unsigned TCDM_BANKS      = 4;
  localparam int unsigned TCDM_BANK_SEL_W = $clog2(TCDM_BANKS);

  // word address, taken from APB address bits 11..2
  localparam int unsigned TCDM_ADDR_W = 10;

  // row in the high bits, bank in the low bits
  typedef struct packed {
    logic [TCDM_ADDR_W-TCDM_BANK_SEL_W-1:0] row;
    logic [TCDM_BANK_SEL_W-1:0]             bank;
  } tcdm_row_bank_t;

  // the same word address, seen flat or split into row and bank
  typedef union packed {
    logic [TCDM_ADDR_W-1:0] index;
    tcdm_row_bank_t         fields;
  } tcdm_word_addr_u;

endpackage

`default_nettype wire

// ==== src/tcdm_top.sv ====
`default_nettype none

module tcdm_top #(
  parameter int unsigned BANK_DEPTH = 64
) (
  input  logic                             clk_i,
  input  logic                             rst_ni,

  // APB port A, core side
  input  logic                             a_psel_i,
  input  logic                             a_penable_i,
  input  logic                             a_pwrite_i,
  input  logic [11:0]                      a_paddr_i,
  input  logic [tcdm_pkg::TCDM_DATA_W-1:0] a_pwdata_i,
  input  logic [tcdm_pkg::TCDM_STRB_W-1:0] a_pstrb_i,
  output logic [tcdm_pkg::TCDM_DATA_W-1:0] a_prdata_o,
  output logic                             a_pready_o,
  output logic                             a_pslverr_o,

  // APB port B, DMA side
  input  logic                             b_psel_i,
  input  logic                             b_penable_i,
  input  logic                             b_pwrite_i,
  input  logic [11:0]                      b_paddr_i,
  input  logic [tcdm_pkg::TCDM_DATA_W-1:0] b_pwdata_i,
  input  logic [tcdm_pkg::TCDM_STRB_W-1:0] b_pstrb_i,
  output logic [tcdm_pkg::TCDM_DATA_W-1:0] b_prdata_o,
  output logic                             b_pready_o,
  output logic                             b_pslverr_o
);

  mem_req_if port_a_mem ();
  mem_req_if port_b_mem ();
  mem_req_if sram_mem ();

  apb_mem_port #(
    .BANK_DEPTH (BANK_DEPTH)
  ) i_port_a (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (a_psel_i),
    .penable_i (a_penable_i),
    .pwrite_i  (a_pwrite_i),
    .paddr_i   (a_paddr_i),
    .pwdata_i  (a_pwdata_i),
    .pstrb_i   (a_pstrb_i),
    .prdata_o  (a_prdata_o),
    .pready_o  (a_pready_o),
    .pslverr_o (a_pslverr_o),
    .mem       (port_a_mem.requester)
  );

  apb_mem_port #(
    .BANK_DEPTH (BANK_DEPTH)
  ) i_port_b (
    .clk_i     (clk_i),
    .rst_ni    (rst_ni),
    .psel_i    (b_psel_i),
    .penable_i (b_penable_i),
    .pwrite_i  (b_pwrite_i),
    .paddr_i   (b_paddr_i),
    .pwdata_i  (b_pwdata_i),
    .pstrb_i   (b_pstrb_i),
    .prdata_o  (b_prdata_o),
    .pready_o  (b_pready_o),
    .pslverr_o (b_pslverr_o),
    .mem       (port_b_mem.requester)
  );

  // port A sits on input 0 and gets the first tie after reset
  mem_arbiter i_arbiter (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req0   (port_a_mem.responder),
    .req1   (port_b_mem.responder),
    .mem    (sram_mem.requester)
  );

  sram #(
    .BANK_DEPTH (BANK_DEPTH)
  ) i_sram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .mem    (sram_mem.responder)
  );

endmodule

`default_nettype wire

// ==== vlog.f ====
src/tcdm_pkg.sv
src/mem_req_if.sv
src/apb_mem_port.sv
src/mem_arbiter.sv
src/sram.sv
src/tcdm_top.sv
dv/tcdm_tb.sv
